// ==== verif/io_golden.txt ====
# op arg data expect, all hex. read/write: arg is the address, data is din, expect is dout.
# send_serial: arg is the stop bit. counters: run and stall cycles. clear: arg is wea.
read           0   0   1
counters       0e  6   0
write          2   41  0
read           0   0   0
write          2   99  0
expect_serial  1   41  0
expect_serial  0   0   0
read           0   0   1
send_serial    1   5a  3
send_random    3   0   3
send_serial    0   33  1
send_serial    1   c3  3
counters       14  a   0
clear          0   0   0
counters       5   3   0
clear          f   0   1
counters       8   4   0
clear          4   0   1
read           3   0   0
read           7   0   0
read           1f  0   0
idle           10  0   0

// ==== build.f ====
rtl/io_pkg.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/perf_counters.sv
rtl/io_control.sv
rtl/io_top.sv
verif/io_tb.sv

// ==== Bender.yml ====
package:
  name: io_block

sources:
  - rtl/io_pkg.sv
  - rtl/uart_tx.sv
  - rtl/uart_rx.sv
  - rtl/perf_counters.sv
  - rtl/io_control.sv
  - rtl/io_top.sv
  - target: test
    files:
      - verif/io_tb.sv

// ==== verif/io_tb.sv ====
`timescale 1ns/1ps

module io_tb;
	localparam int CLK_FREQ   = 1_000_000;
	localparam int BAUD       = 100_000;
	localparam int BIT_CLKS   = CLK_FREQ / BAUD;
	localparam int FRAME_CLKS = 10 * BIT_CLKS;

	logic               clk;
	logic               cpu_rst;
	logic               io_load;
	logic               io_store;
	logic [3:0]         wea;
	io_pkg::io_adr_t    adr;
	io_pkg::xlen_word_t din;
	io_pkg::xlen_word_t dout;
	logic               instr_stop;
	logic               serial_in;
	logic               serial_out;
	logic               clear_model;
	io_pkg::xlen_word_t ref_cycle;
	io_pkg::xlen_word_t ref_instr;
	logic [127:0]       op_q[$];
	logic [31:0]        arg_q[$];
	logic [31:0]        data_q[$];
	logic [31:0]        exp_q[$];
	io_pkg::uart_byte_t tx_bytes[$];
	logic [15:0]        lfsr;
	int                 errors;
	int                 cycles;
	int                 limit;

	io_top #(
		.CPU_CLOCK_FREQ (CLK_FREQ),
		.BAUD_RATE      (BAUD)
	) uut (
		.clk        (clk),
		.cpu_rst    (cpu_rst),
		.io_load    (io_load),
		.io_store   (io_store),
		.wea        (wea),
		.adr        (adr),
		.din        (din),
		.instr_stop (instr_stop),
		.serial_in  (serial_in),
		.dout       (dout),
		.serial_out (serial_out)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// reference counters follow reset, clear and stall.
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cpu_rst || clear_model) begin
			ref_cycle <= '0;
			ref_instr <= '0;
		end else begin
			ref_cycle <= ref_cycle + 1;
			if (!instr_stop)
				ref_instr <= ref_instr + 1;
		end
		if (limit > 0 && cycles >= limit) begin
			$display("run timed out after %0d cycles", cycles);
			$display("Something failed");
			$finish;
		end
	end

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED at time %0t: %s, got %h, expected %h", $time, what, actual,
				expected);
		end
	endtask

	// decodes frames on serial_out, sampled on falling clk near mid-bit.
	initial begin : tx_monitor
		io_pkg::uart_byte_t got;
		wait (cpu_rst === 1'b0);
		forever begin
			@(negedge serial_out);
			repeat (BIT_CLKS / 2) @(negedge clk);
			check_value(serial_out, 0, "tx start bit");
			for (int i = 0; i < 8; i++) begin
				repeat (BIT_CLKS) @(negedge clk);
				got[i] = serial_out; // LSB first.
			end
			repeat (BIT_CLKS) @(negedge clk);
			check_value(serial_out, 1, "tx stop bit");
			tx_bytes.push_back(got);
		end
	end

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic random_byte(output io_pkg::uart_byte_t b);
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr_step(lfsr);
			b[i] = lfsr[0];
		end
	endtask

	// every bus task starts and ends 2 ns after a rising edge.
	task automatic wait_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic read_word(input io_pkg::io_adr_t a, output io_pkg::xlen_word_t val);
		adr = a;
		io_load = 1'b1;
		@(posedge clk);
		#1 val = dout;
		#1 io_load = 1'b0;
	endtask

	task automatic read_check(input io_pkg::io_adr_t a, input logic [31:0] exp, input string what);
		io_pkg::xlen_word_t got;
		read_word(a, got);
		check_value(got, exp, what);
	endtask

	task automatic write_word(input io_pkg::io_adr_t a, input logic [31:0] d, input logic [3:0] w);
		adr = a;
		din = d;
		wea = w;
		io_store = 1'b1;
		@(posedge clk);
		#2 io_store = 1'b0;
	endtask

	// expected values are taken before the edge that loads dout.
	task automatic check_counters(output io_pkg::xlen_word_t got_c, output io_pkg::xlen_word_t got_i);
		io_pkg::xlen_word_t exp_c;
		io_pkg::xlen_word_t exp_i;
		exp_c = ref_cycle;
		read_word(io_pkg::ADR_CYCLE_CNT, got_c);
		exp_i = ref_instr;
		read_word(io_pkg::ADR_INSTR_CNT, got_i);
		check_value(got_c, exp_c, "cycle counter");
		check_value(got_i, exp_i, "instruction counter");
	endtask

	task automatic send_frame(input io_pkg::uart_byte_t b, input logic stop_level);
		logic [9:0] bits;
		bits = {stop_level, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			serial_in = bits[i];
			wait_cycles(BIT_CLKS);
		end
		serial_in = 1'b1;
	endtask

	task automatic receive_test(input io_pkg::uart_byte_t b, input logic stop_level,
			input logic [31:0] exp_ctrl);
		send_frame(b, stop_level);
		read_check(io_pkg::ADR_UART_CTRL, exp_ctrl, "control after frame");
		if (exp_ctrl[1]) begin
			read_check(io_pkg::ADR_UART_RX, {24'd0, b}, "received byte");
			read_check(io_pkg::ADR_UART_CTRL, exp_ctrl & 32'hFFFF_FFFD, "control after consume");
		end
	endtask

	task automatic run_op(input logic [127:0] op, input logic [31:0] a, input logic [31:0] d,
			input logic [31:0] e);
		io_pkg::uart_byte_t b;
		io_pkg::xlen_word_t got_c;
		io_pkg::xlen_word_t got_i;
		if (op == "read") begin
			read_check(a[4:0], e, "read data");
		end else if (op == "write") begin
			write_word(a[4:0], d, 4'hF);
		end else if (op == "idle") begin
			wait_cycles(a);
		end else if (op == "counters") begin
			instr_stop = 1'b0;
			wait_cycles(a);
			instr_stop = 1'b1;
			wait_cycles(d);
			instr_stop = 1'b0;
			check_counters(got_c, got_i);
			check_value(got_c > got_i, 1, "cycle count above instruction count");
		end else if (op == "clear") begin
			clear_model = e[0];
			write_word(io_pkg::ADR_CNT_CLEAR, '0, a[3:0]);
			clear_model = 1'b0;
			check_counters(got_c, got_i);
		end else if (op == "expect_serial") begin
			if (a[0]) begin
				while (tx_bytes.size() == 0)
					wait_cycles(1);
				check_value(tx_bytes.pop_front(), d, "transmitted byte");
			end else begin
				wait_cycles(2 * FRAME_CLKS); // a dropped store must not start a frame.
				check_value(tx_bytes.size(), 0, "frames sent after the last one");
			end
		end else if (op == "send_serial") begin
			receive_test(d[7:0], a[0], e);
		end else if (op == "send_random") begin
			repeat (a) begin
				random_byte(b);
				receive_test(b, 1'b1, e);
			end
		end else begin
			errors++;
			$display("unknown operation %0s in the golden file", op);
		end
	endtask

	task automatic load_golden(output logic ok);
		int           fd;
		string        line;
		logic [127:0] op;
		logic [31:0]  a;
		logic [31:0]  d;
		logic [31:0]  e;
		fd = $fopen("verif/io_golden.txt", "r");
		ok = (fd != 0);
		if (ok) begin
			while ($fgets(line, fd) > 0) begin
				if (line.getc(0) != "#" && $sscanf(line, "%s %h %h %h", op, a, d, e) == 4) begin
					op_q.push_back(op);
					arg_q.push_back(a);
					data_q.push_back(d);
					exp_q.push_back(e);
				end
			end
			$fclose(fd);
			ok = (op_q.size() > 0);
		end
	endtask

	initial begin
		logic file_ok;
		int   start_errors;
		int   passed;
		int   failed;
		cpu_rst = 1'b1;
		io_load = 1'b0;
		io_store = 1'b0;
		wea = '0;
		adr = '0;
		din = '0;
		instr_stop = 1'b1; // stalled through reset, so cycles lead instructions.
		serial_in = 1'b1;
		clear_model = 1'b0;
		lfsr = 16'd25838;
		errors = 0;
		cycles = 0;
		limit = 0;
		passed = 0;
		failed = 0;
		load_golden(file_ok);
		if (!file_ok) begin
			$display("could not read any operation from verif/io_golden.txt");
			$display("Something failed");
		end else begin
			limit = op_q.size() * 12 * FRAME_CLKS;
			repeat (4) @(posedge clk);
			#2 cpu_rst = 1'b0;
			wait_cycles(3);
			instr_stop = 1'b0;
			for (int t = 0; t < op_q.size(); t++) begin
				start_errors = errors;
				run_op(op_q[t], arg_q[t], data_q[t], exp_q[t]);
				if (errors == start_errors)
					passed++;
				else
					failed++;
				$display("test %0d %0s: %s", t + 1, op_q[t],
					(errors == start_errors) ? "passed" : "failed");
			end
			$display("%0d tests passed, %0d tests failed", passed, failed);
			if (errors == 0)
				$display("Everything OK");
			else
				$display("Something failed");
		end
		$finish;
	end

endmodule

// ==== rtl/io_top.sv ====
`timescale 1ns/1ps

module io_top #(
	parameter int CPU_CLOCK_FREQ = 50_000_000,
	parameter int BAUD_RATE      = 115_200
) (
	input  logic               clk,
	input  logic               cpu_rst,
	input  logic               io_load,
	input  logic               io_store,
	input  logic [3:0]         wea,
	input  io_pkg::io_adr_t    adr,
	input  io_pkg::xlen_word_t din,
	input  logic               instr_stop,
	input  logic               serial_in,
	output io_pkg::xlen_word_t dout,
	output logic               serial_out
);
	io_pkg::uart_tx_req_t tx_req;
	io_pkg::uart_status_t status;
	io_pkg::uart_byte_t   rx_data;
	io_pkg::xlen_word_t   cycle_cnt;
	io_pkg::xlen_word_t   instr_cnt;
	logic                 tx_ready;
	logic                 rx_valid;
	logic                 rx_consume;
	logic                 cnt_clear;

	assign status = '{rx_valid: rx_valid, tx_ready: tx_ready};

	io_control u_io_control (
		.clk        (clk),
		.cpu_rst    (cpu_rst),
		.io_load    (io_load),
		.io_store   (io_store),
		.wea        (wea),
		.adr        (adr),
		.din        (din),
		.status     (status),
		.rx_data    (rx_data),
		.cycle_cnt  (cycle_cnt),
		.instr_cnt  (instr_cnt),
		.dout       (dout),
		.tx_req     (tx_req),
		.rx_consume (rx_consume),
		.cnt_clear  (cnt_clear)
	);

	uart_tx #(
		.CPU_CLOCK_FREQ (CPU_CLOCK_FREQ),
		.BAUD_RATE      (BAUD_RATE)
	) u_uart_tx (
		.clk        (clk),
		.cpu_rst    (cpu_rst),
		.tx_req     (tx_req),
		.tx_ready   (tx_ready),
		.serial_out (serial_out)
	);

	uart_rx #(
		.CPU_CLOCK_FREQ (CPU_CLOCK_FREQ),
		.BAUD_RATE      (BAUD_RATE)
	) u_uart_rx (
		.clk        (clk),
		.cpu_rst    (cpu_rst),
		.serial_in  (serial_in),
		.rx_consume (rx_consume),
		.rx_valid   (rx_valid),
		.rx_data    (rx_data)
	);

	perf_counters u_perf_counters (
		.clk        (clk),
		.cpu_rst    (cpu_rst),
		.cnt_clear  (cnt_clear),
		.instr_stop (instr_stop),
		.cycle_cnt  (cycle_cnt),
		.instr_cnt  (instr_cnt)
	);

endmodule

// ==== rtl/io_control.sv ====
`timescale 1ns/1ps

module io_control (
	input  logic                 clk,
	input  logic                 cpu_rst,
	input  logic                 io_load,
	input  logic                 io_store,
	input  logic [3:0]           wea,
	input  io_pkg::io_adr_t      adr,
	input  io_pkg::xlen_word_t   din,
	input  io_pkg::uart_status_t status,
	input  io_pkg::uart_byte_t   rx_data,
	input  io_pkg::xlen_word_t   cycle_cnt,
	input  io_pkg::xlen_word_t   instr_cnt,
	output io_pkg::xlen_word_t   dout,
	output io_pkg::uart_tx_req_t tx_req,
	output logic                 rx_consume,
	output logic                 cnt_clear
);
	logic               sel_tx;
	logic               sel_rx;
	logic               sel_clear;
	io_pkg::xlen_word_t ctrl_word;

	assign sel_tx    = (adr == io_pkg::ADR_UART_TX);
	assign sel_rx    = (adr == io_pkg::ADR_UART_RX);
	assign sel_clear = (adr == io_pkg::ADR_CNT_CLEAR);

	assign ctrl_word = {30'd0, status.rx_valid, status.tx_ready};

	// stores while the transmitter is busy are dropped.
	assign tx_req.valid = io_store && sel_tx && status.tx_ready;
	assign tx_req.data  = din[7:0];

	assign rx_consume = io_load && sel_rx && status.rx_valid;
	assign cnt_clear  = io_store && sel_clear && (wea != 4'd0);

	// read mux is registered every cycle, load strobe or not.
	always_ff @(posedge clk) begin
		if (cpu_rst) begin
			dout <= '0;
		end else begin
			case (adr)
				io_pkg::ADR_UART_CTRL: dout <= ctrl_word;
				io_pkg::ADR_UART_RX:   dout <= {24'd0, rx_data};
				io_pkg::ADR_CYCLE_CNT: dout <= cycle_cnt;
				io_pkg::ADR_INSTR_CNT: dout <= instr_cnt;
				default:               dout <= '0; // unmapped and write-only.
			endcase
		end
	end

	// the transmitter must leave ready on the edge that takes the byte.
	a_tx_req_ready: assert property (@(posedge clk) disable iff (cpu_rst)
		tx_req.valid |-> status.tx_ready ##1 !status.tx_ready);

endmodule

// ==== rtl/perf_counters.sv ====
`timescale 1ns/1ps

module perf_counters (
	input  logic               clk,
	input  logic               cpu_rst,
	input  logic               cnt_clear,
	input  logic               instr_stop,
	output io_pkg::xlen_word_t cycle_cnt,
	output io_pkg::xlen_word_t instr_cnt
);
	logic zero_cnt;

	assign zero_cnt = cpu_rst || cnt_clear;

	always_ff @(posedge clk) begin
		if (zero_cnt)
			cycle_cnt <= '0;
		else
			cycle_cnt <= cycle_cnt + 1'b1;
	end

	// a cycle without a stall retires one instruction.
	always_ff @(posedge clk) begin
		if (zero_cnt)
			instr_cnt <= '0;
		else if (!instr_stop)
			instr_cnt <= instr_cnt + 1'b1;
	end

endmodule

// ==== rtl/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx #(
	parameter int CPU_CLOCK_FREQ = 50_000_000,
	parameter int BAUD_RATE      = 115_200
) (
	input  logic               clk,
	input  logic               cpu_rst,
	input  logic               serial_in,
	input  logic               rx_consume,
	output logic               rx_valid,
	output io_pkg::uart_byte_t rx_data
);
	localparam int CLKS_PER_BIT = CPU_CLOCK_FREQ / BAUD_RATE;
	localparam int CNT_W        = $clog2(CLKS_PER_BIT + 1);

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	rx_state_t          state;
	logic [2:0]         sync_q; // two sync stages plus one for edge detect.
	logic               serial_s;
	logic               serial_fall;
	logic [CNT_W-1:0]   clk_cnt;
	logic [2:0]         bit_idx;
	io_pkg::uart_byte_t shift_q;
	logic               bit_done;
	logic               half_done;
	logic               frame_ok;

	assign serial_s    = sync_q[1];
	assign serial_fall = sync_q[2] && !sync_q[1];
	assign bit_done    = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));
	assign half_done   = (clk_cnt == CNT_W'(CLKS_PER_BIT / 2 - 1));
	assign frame_ok    = (state == RX_STOP) && bit_done && serial_s; // low stop bit drops the frame.

	always_ff @(posedge clk) begin
		if (state == RX_DATA && bit_done)
			shift_q <= {serial_s, shift_q[7:1]};
		if (frame_ok)
			rx_data <= shift_q;
	end

	always_ff @(posedge clk) begin
		if (cpu_rst) begin
			sync_q   <= 3'b111;
			state    <= RX_IDLE;
			clk_cnt  <= '0;
			bit_idx  <= '0;
			rx_valid <= 1'b0;
		end else begin
			sync_q  <= {sync_q[1:0], serial_in};
			clk_cnt <= (state == RX_IDLE || bit_done) ? '0 : clk_cnt + 1'b1;
			if (frame_ok)
				rx_valid <= 1'b1; // overrun simply replaces the byte.
			else if (rx_consume)
				rx_valid <= 1'b0;
			case (state)
				RX_IDLE: begin
					if (serial_fall)
						state <= RX_START;
				end
				RX_START: begin
					if (half_done) begin
						clk_cnt <= '0; // realign to mid-bit.
						bit_idx <= '0;
						state   <= serial_s ? RX_IDLE : RX_DATA;
					end
				end
				RX_DATA: begin
					if (bit_done) begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= RX_STOP;
					end
				end
				default: begin
					if (bit_done)
						state <= RX_IDLE;
				end
			endcase
		end
	end

	a_consume_valid: assert property (@(posedge clk) disable iff (cpu_rst)
		rx_consume |-> rx_valid);

endmodule

// ==== rtl/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx #(
	parameter int CPU_CLOCK_FREQ = 50_000_000,
	parameter int BAUD_RATE      = 115_200
) (
	input  logic                 clk,
	input  logic                 cpu_rst,
	input  io_pkg::uart_tx_req_t tx_req,
	output logic                 tx_ready,
	output logic                 serial_out
);
	localparam int CLKS_PER_BIT = CPU_CLOCK_FREQ / BAUD_RATE;
	localparam int CNT_W        = $clog2(CLKS_PER_BIT + 1);

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_t;

	tx_state_t          state;
	logic [CNT_W-1:0]   clk_cnt;
	logic [2:0]         bit_idx;
	io_pkg::uart_byte_t shift_q;
	logic               bit_done;
	logic               frame_start;
	logic               shift_step;

	assign bit_done    = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));
	assign frame_start = (state == TX_IDLE) && tx_req.valid;
	assign shift_step  = bit_done && ((state == TX_START) || (state == TX_DATA));
	assign tx_ready    = (state == TX_IDLE);

	always_ff @(posedge clk) begin
		if (frame_start)
			shift_q <= tx_req.data;
		else if (shift_step)
			shift_q <= shift_q >> 1; // LSB goes out first.
	end

	always_ff @(posedge clk) begin
		if (cpu_rst) begin
			state      <= TX_IDLE;
			clk_cnt    <= '0;
			bit_idx    <= '0;
			serial_out <= 1'b1; // line idles high.
		end else begin
			clk_cnt <= (state == TX_IDLE || bit_done) ? '0 : clk_cnt + 1'b1;
			case (state)
				TX_IDLE: begin
					if (tx_req.valid) begin
						state      <= TX_START;
						serial_out <= 1'b0; // start bit.
					end
				end
				TX_START: begin
					if (bit_done) begin
						state      <= TX_DATA;
						bit_idx    <= '0;
						serial_out <= shift_q[0];
					end
				end
				TX_DATA: begin
					if (bit_done) begin
						if (bit_idx == 3'd7) begin
							state      <= TX_STOP;
							serial_out <= 1'b1; // stop bit.
						end else begin
							bit_idx    <= bit_idx + 1'b1;
							serial_out <= shift_q[0];
						end
					end
				end
				default: begin
					if (bit_done)
						state <= TX_IDLE;
				end
			endcase
		end
	end

	a_idle_line_high: assert property (@(posedge clk) disable iff (cpu_rst)
		state == TX_IDLE |-> serial_out);

endmodule

// ==== rtl/io_pkg.sv ====
package io_pkg;

	// widths that carry a meaning on the core side.
	typedef logic [31:0] xlen_word_t;
	typedef logic [7:0]  uart_byte_t;
	typedef logic [4:0]  io_adr_t;

	// I/O word address map.
	localparam io_adr_t ADR_UART_CTRL = 5'd0; // {rx_valid, tx_ready} in bits 1:0.
	localparam io_adr_t ADR_UART_RX   = 5'd1; // load consumes the byte.
	localparam io_adr_t ADR_UART_TX   = 5'd2;
	localparam io_adr_t ADR_CYCLE_CNT = 5'd4;
	localparam io_adr_t ADR_INSTR_CNT = 5'd5;
	localparam io_adr_t ADR_CNT_CLEAR = 5'd6; // store with any byte enable.

	// bit 1 is rx_valid and bit 0 is tx_ready, matching the control word.
	typedef struct packed {
		logic rx_valid;
		logic tx_ready;
	} uart_status_t;

	// single-cycle byte request toward the transmitter.
	typedef struct packed {
		logic       valid;
		uart_byte_t data;
	} uart_tx_req_t;

endpackage
